// File: hdl/neoVideoPkg.sv
// Widths and colour-word fields of the Neo Geo palette path, fixed to the 16-bit hardware format
package neoVideoPkg;

	//====================================================================
	// Bus widths
	//====================================================================

	// Palette address within one bank
	localparam int PAL_ADDR_W = 12;

	// Palette colour word as stored in RAM
	localparam int COLOR_W = 16;

	// One output channel of the RGB stream
	localparam int CHANNEL_W = 8;

	//====================================================================
	// System latch
	//====================================================================

	// Top bit carries the written value, low three bits pick the latch
	localparam int LATCH_SEL_W = 4;

	// Latch selectors kept by this design
	localparam logic [LATCH_SEL_W-2:0] LATCH_SHADOW  = 3'd0;
	localparam logic [LATCH_SEL_W-2:0] LATCH_PALBANK = 3'd7;

	//====================================================================
	// Colour word layout
	//====================================================================

	// Shared dark bit and the per-channel extra low bits
	localparam int DARK_BIT      = 15;
	localparam int RED_LSB_BIT   = 14;
	localparam int GREEN_LSB_BIT = 13;
	localparam int BLUE_LSB_BIT  = 12;

	// Lowest bit of each 4-bit main nibble
	localparam int RED_HI_LSB   = 8;
	localparam int GREEN_HI_LSB = 4;
	localparam int BLUE_HI_LSB  = 0;

	// Payload types
	typedef logic [COLOR_W-1:0]   colorWord_t;
	typedef logic [CHANNEL_W-1:0] channel_t;

endpackage

// File: hdl/pixelClockGen.sv
// Needs PIXEL_DIVIDE of 2 or more; every output is a clock enable in the CLK_48M domain
`timescale 1ns/1ps

module pixelClockGen #(
	parameter int PIXEL_DIVIDE = 8
) (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic enable24P,
	output logic enable24N,
	output logic pixelEnable
);

	// Counter just wide enough for the divide ratio
	localparam int COUNT_W = (PIXEL_DIVIDE > 1) ? $clog2(PIXEL_DIVIDE) : 1;
	localparam logic [COUNT_W-1:0] COUNT_LAST = COUNT_W'(PIXEL_DIVIDE - 1);

	logic               halfPhase;
	logic [COUNT_W-1:0] divCount;

	//====================================================================
	// 24 MHz enable pair
	//====================================================================

	// Toggles every master cycle
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			halfPhase <= 1'b0;
		end else begin
			halfPhase <= ~halfPhase;
		end
	end

	// Complementary phases of the same toggle
	assign enable24N = halfPhase;
	assign enable24P = ~halfPhase;

	//====================================================================
	// Pixel enable
	//====================================================================

	// Free-running divider, pulse on wrap
	// First pulse lands PIXEL_DIVIDE cycles after reset release
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			divCount    <= '0;
			pixelEnable <= 1'b0;
		end else begin
			pixelEnable <= (divCount == COUNT_LAST);
			if (divCount == COUNT_LAST) begin
				divCount <= '0;
			end else begin
				divCount <= divCount + COUNT_W'(1);
			end
		end
	end

	// Downstream stages count on an isolated one-cycle strobe
	pixelEnableSingle: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		pixelEnable |=> !pixelEnable)
		else $error("pixelEnable high on two consecutive cycles");

endmodule

// File: hdl/systemLatch.sv
// Only shadow and palette-bank selectors are kept; writes to any other selector are dropped
`timescale 1ns/1ps

module systemLatch (
	input  logic                               CLK_48M,
	input  logic                               nRESET,
	input  logic                               latchWrite,
	input  logic [neoVideoPkg::LATCH_SEL_W-1:0] latchAddr,
	output logic                               shadow,
	output logic                               palBank
);

	// Address split into selector and data bit
	logic [neoVideoPkg::LATCH_SEL_W-2:0] latchSel;
	logic                                latchValue;

	assign latchSel   = latchAddr[neoVideoPkg::LATCH_SEL_W-2:0];
	assign latchValue = latchAddr[neoVideoPkg::LATCH_SEL_W-1];

	//====================================================================
	// Flag registers
	//====================================================================

	// New value visible the cycle after the strobe
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow  <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWrite) begin
			case (latchSel)
				// Halves the RGB output
				neoVideoPkg::LATCH_SHADOW: begin
					shadow <= latchValue;
				end
				// Picks the palette bank for both RAM ports
				neoVideoPkg::LATCH_PALBANK: begin
					palBank <= latchValue;
				end
				// Selectors of removed functions
				default: begin
				end
			endcase
		end
	end

	// An unknown selector would leave both flags in doubt
	latchAddrKnown: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		latchWrite |-> !$isunknown(latchAddr))
		else $error("latchAddr unknown during latchWrite");

endmodule

// File: hdl/paletteRam.sv
// Read-before-write on a shared address; palBank is one bit so only banks 0 and 1 are reachable
`timescale 1ns/1ps

module paletteRam #(
	parameter int BANK_COUNT = 2
) (
	input  logic                              CLK_48M,
	input  logic                              palBank,
	input  logic [neoVideoPkg::PAL_ADDR_W-1:0] cpuPalAddr,
	input  neoVideoPkg::colorWord_t           cpuPalData,
	input  logic                              cpuPalWrite,
	input  logic [neoVideoPkg::PAL_ADDR_W-1:0] pixelPalAddr,
	output neoVideoPkg::colorWord_t           palData
);

	//====================================================================
	// Storage
	//====================================================================

	// Banks of 4096 colour words each
	neoVideoPkg::colorWord_t paletteMem [BANK_COUNT][2**neoVideoPkg::PAL_ADDR_W];

	// CPU port
	// Writes land in whichever bank is currently selected
	always_ff @(posedge CLK_48M) begin
		if (cpuPalWrite) begin
			paletteMem[palBank][cpuPalAddr] <= cpuPalData;
		end
	end

	// Video port
	// One-cycle registered read, old word on a colliding write
	always_ff @(posedge CLK_48M) begin
		palData <= paletteMem[palBank][pixelPalAddr];
	end

	//====================================================================
	// Checks
	//====================================================================

	// A write with an unknown address could corrupt any entry
	cpuAddrKnown: assert property (@(posedge CLK_48M)
		cpuPalWrite |-> !$isunknown(cpuPalAddr))
		else $error("cpuPalAddr unknown during cpuPalWrite");

endmodule

// File: hdl/videoOutput.sv
// Expects palData and shadow settled by the pixelEnable cycle; outputs update only at the pixel rate
`timescale 1ns/1ps

module videoOutput (
	input  logic                    CLK_48M,
	input  logic                    nRESET,
	input  logic                    pixelEnable,
	input  logic                    shadow,
	input  neoVideoPkg::colorWord_t palData,
	input  logic                    hblankIn,
	input  logic                    vblankIn,
	output neoVideoPkg::channel_t   red,
	output neoVideoPkg::channel_t   green,
	output neoVideoPkg::channel_t   blue,
	output logic                    hblank,
	output logic                    vblank
);

	// Main nibble and intermediate level widths
	localparam int NIBBLE_W = 4;
	localparam int LEVEL_W  = 6;

	//====================================================================
	// Colour conversion
	//====================================================================

	// Nibble, own low bit, then nibble MSB repeated
	// Dark bit takes one step off, clamped at zero
	// Bits 4 and 3 fill the bottom of the 8-bit value
	function automatic neoVideoPkg::channel_t convertChannel(
		input logic [NIBBLE_W-1:0] mainNibble,
		input logic                lowBit,
		input logic                darkBit
	);
		logic [LEVEL_W:0] level;
		level = {1'b0, mainNibble, lowBit, mainNibble[NIBBLE_W-1]}
			- {{LEVEL_W{1'b0}}, darkBit};
		// Borrow out means 0 minus dark
		if (level[LEVEL_W]) begin
			return '0;
		end
		return {level[LEVEL_W-1:0], level[4:3]};
	endfunction

	neoVideoPkg::channel_t redLevel;
	neoVideoPkg::channel_t greenLevel;
	neoVideoPkg::channel_t blueLevel;
	neoVideoPkg::channel_t redShaded;
	neoVideoPkg::channel_t greenShaded;
	neoVideoPkg::channel_t blueShaded;
	logic                  hblankStage;

	always_comb begin
		redLevel = convertChannel(palData[neoVideoPkg::RED_HI_LSB +: NIBBLE_W],
			palData[neoVideoPkg::RED_LSB_BIT], palData[neoVideoPkg::DARK_BIT]);
		greenLevel = convertChannel(palData[neoVideoPkg::GREEN_HI_LSB +: NIBBLE_W],
			palData[neoVideoPkg::GREEN_LSB_BIT], palData[neoVideoPkg::DARK_BIT]);
		blueLevel = convertChannel(palData[neoVideoPkg::BLUE_HI_LSB +: NIBBLE_W],
			palData[neoVideoPkg::BLUE_LSB_BIT], palData[neoVideoPkg::DARK_BIT]);
	end

	// Shadow halves every channel
	always_comb begin
		redShaded   = shadow ? (redLevel >> 1) : redLevel;
		greenShaded = shadow ? (greenLevel >> 1) : greenLevel;
		blueShaded  = shadow ? (blueLevel >> 1) : blueLevel;
	end

	//====================================================================
	// Pixel-rate registers
	//====================================================================

	// vblank one pixel late, hblank two pixels late
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red         <= '0;
			green       <= '0;
			blue        <= '0;
			hblankStage <= 1'b0;
			hblank      <= 1'b0;
			vblank      <= 1'b0;
		end else if (pixelEnable) begin
			red         <= redShaded;
			green       <= greenShaded;
			blue        <= blueShaded;
			hblankStage <= hblankIn;
			hblank      <= hblankStage;
			vblank      <= vblankIn;
		end
	end

endmodule

// File: hdl/neoVideoTop.sv
// Renderer inputs must hold for a full pixel; the 24 MHz enables are left open for later renderers
`timescale 1ns/1ps

module neoVideoTop #(
	parameter int PIXEL_DIVIDE = 8,
	parameter int BANK_COUNT   = 2
) (
	input  logic                              CLK_48M,
	input  logic                              nRESET,

	// CPU side
	input  logic [neoVideoPkg::PAL_ADDR_W-1:0] cpuPalAddr,
	input  neoVideoPkg::colorWord_t           cpuPalData,
	input  logic                              cpuPalWrite,
	input  logic                              latchWrite,
	input  logic [neoVideoPkg::LATCH_SEL_W-1:0] latchAddr,

	// Renderer side
	input  logic [neoVideoPkg::PAL_ADDR_W-1:0] pixelPalAddr,
	input  logic                              hblankIn,
	input  logic                              vblankIn,

	// Video out
	output neoVideoPkg::channel_t             red,
	output neoVideoPkg::channel_t             green,
	output neoVideoPkg::channel_t             blue,
	output logic                              hblank,
	output logic                              vblank,
	output logic                              cePixel
);

	// Latch flags
	logic shadow;
	logic palBank;

	// Palette word heading into conversion
	neoVideoPkg::colorWord_t palData;

	//====================================================================
	// Clock enables
	//====================================================================

	// Pixel strobe doubles as the cePixel output
	pixelClockGen #(
		.PIXEL_DIVIDE(PIXEL_DIVIDE)
	) clockGen (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.enable24P  (),
		.enable24N  (),
		.pixelEnable(cePixel)
	);

	//====================================================================
	// CPU-visible state
	//====================================================================

	systemLatch latch (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.latchWrite(latchWrite),
		.latchAddr (latchAddr),
		.shadow    (shadow),
		.palBank   (palBank)
	);

	// Bank flag steers CPU writes and video reads alike
	paletteRam #(
		.BANK_COUNT(BANK_COUNT)
	) palette (
		.CLK_48M     (CLK_48M),
		.palBank     (palBank),
		.cpuPalAddr  (cpuPalAddr),
		.cpuPalData  (cpuPalData),
		.cpuPalWrite (cpuPalWrite),
		.pixelPalAddr(pixelPalAddr),
		.palData     (palData)
	);

	//====================================================================
	// Output stage
	//====================================================================

	videoOutput video (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.pixelEnable(cePixel),
		.shadow     (shadow),
		.palData    (palData),
		.hblankIn   (hblankIn),
		.vblankIn   (vblankIn),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.hblank     (hblank),
		.vblank     (vblank)
	);

endmodule

// File: bench/colorModel.svh
// Reference for the Neo Geo colour rule and blank delays; assumes the 16-bit word layout of neoVideoPkg
`ifndef COLOR_MODEL_SVH
`define COLOR_MODEL_SVH

// 6-bit level from nibble, own low bit and nibble MSB, one step lower when dark
function automatic int levelOf(input logic [3:0] nibble, input logic lowBit, input logic dark);
	int level;
	level = 4 * int'(nibble) + 2 * int'(lowBit) + int'(nibble[3]) - int'(dark);
	// Dark on a black channel stays black
	if (level < 0) begin
		level = 0;
	end
	return level;
endfunction

// Expected 8-bit channel; 0 is red, 1 green, 2 blue
function automatic neoVideoPkg::channel_t modelChannel(input neoVideoPkg::colorWord_t word,
	input int channel, input logic shade);
	logic [3:0] nibble;
	logic       lowBit;
	int         wide;
	case (channel)
		0: begin
			nibble = word[neoVideoPkg::RED_HI_LSB +: 4];
			lowBit = word[neoVideoPkg::RED_LSB_BIT];
		end
		1: begin
			nibble = word[neoVideoPkg::GREEN_HI_LSB +: 4];
			lowBit = word[neoVideoPkg::GREEN_LSB_BIT];
		end
		default: begin
			nibble = word[neoVideoPkg::BLUE_HI_LSB +: 4];
			lowBit = word[neoVideoPkg::BLUE_LSB_BIT];
		end
	endcase
	// Level bits 4 and 3 land in the two bottom bits
	wide = 4 * levelOf(nibble, lowBit, word[neoVideoPkg::DARK_BIT]);
	wide = wide + (wide / 32) % 4;
	// Shadow is half brightness
	if (shade) begin
		wide = wide / 2;
	end
	return 8'(wide);
endfunction

// Blank level from a number of pixel strobes back, newest in bit 0
function automatic logic pastBlank(input logic [3:0] history, input int pixelsBack);
	return history[pixelsBack - 1];
endfunction

`endif

// File: bench/tbNeoVideo.sv
// Expects PIXEL_DIVIDE of 8 in the DUT; rows 0 to 5 are fixed corner cases, the rest random
`timescale 1ns/1ps

module tbNeoVideo;

	localparam int ROWS       = 12;
	localparam int DIVIDE     = 8;
	localparam int WAIT_LIMIT = 4 * DIVIDE;
	localparam neoVideoPkg::colorWord_t CORNER_WORDS [6] = '{16'h8000, 16'h7FFF, 16'hFFFF,
		16'h0000, 16'h1234, 16'h6BCD};

	logic                                CLK_48M;
	logic                                nRESET;
	logic [neoVideoPkg::PAL_ADDR_W-1:0]  cpuPalAddr;
	neoVideoPkg::colorWord_t             cpuPalData;
	logic                                cpuPalWrite;
	logic                                latchWrite;
	logic [neoVideoPkg::LATCH_SEL_W-1:0] latchAddr;
	logic [neoVideoPkg::PAL_ADDR_W-1:0]  pixelPalAddr;
	logic                                hblankIn;
	logic                                vblankIn;
	neoVideoPkg::channel_t               red;
	neoVideoPkg::channel_t               green;
	neoVideoPkg::channel_t               blue;
	logic                                hblank;
	logic                                vblank;
	logic                                cePixel;

	// Stimulus table, one pixel per row
	logic [neoVideoPkg::PAL_ADDR_W-1:0] rowAddr [ROWS];
	logic                               rowBank [ROWS];
	neoVideoPkg::colorWord_t            rowWord [ROWS];
	logic                               rowShadow [ROWS];
	logic                               rowHblank [ROWS];
	logic                               rowVblank [ROWS];

	int         errorCount;
	int         timeoutCount;
	int         blankChecks;
	int         gap;
	logic [3:0] hblankHistory;
	logic [3:0] vblankHistory;

	`include "colorModel.svh"

	neoVideoTop #(.PIXEL_DIVIDE(DIVIDE), .BANK_COUNT(2)) dut (.*);

	always #5 CLK_48M = ~CLK_48M;

	//======================================================================
	// Helpers
	//======================================================================

	// Drive point, 1 ns past the rising edge
	task automatic stepClock();
		@(posedge CLK_48M);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			$display("Fail time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkIdle();
		checkValue("cePixel", 8'd0, cePixel);
		checkValue("red", 8'd0, red);
		checkValue("green", 8'd0, green);
		checkValue("blue", 8'd0, blue);
		checkValue("hblank", 8'd0, hblank);
		checkValue("vblank", 8'd0, vblank);
	endtask

	// Next cePixel cycle, gap holds the cycles taken
	task automatic waitPixel();
		gap = 0;
		do begin
			stepClock();
			gap++;
		end while (cePixel !== 1'b1 && gap < WAIT_LIMIT);
		if (cePixel !== 1'b1) begin
			$display("Timeout at %0t: no cePixel pulse within %0d cycles", $time, WAIT_LIMIT);
			timeoutCount++;
		end
	endtask

	task automatic writeLatch(input logic [2:0] sel, input logic value);
		latchAddr  = {value, sel};
		latchWrite = 1'b1;
		stepClock();
		latchWrite = 1'b0;
	endtask

	// Lands in the bank currently selected
	task automatic writePalette(input int row);
		cpuPalAddr  = rowAddr[row];
		cpuPalData  = rowWord[row];
		cpuPalWrite = 1'b1;
		stepClock();
		cpuPalWrite = 1'b0;
	endtask

	// Hold one pixel across a full strobe interval, then step past the register
	task automatic showPixel(input int row, input logic shade);
		writeLatch(neoVideoPkg::LATCH_PALBANK, rowBank[row]);
		writeLatch(neoVideoPkg::LATCH_SHADOW, shade);
		pixelPalAddr = rowAddr[row];
		hblankIn     = rowHblank[row];
		vblankIn     = rowVblank[row];
		waitPixel();
		waitPixel();
		stepClock();
		checkValue("red", modelChannel(rowWord[row], 0, shade), red);
		checkValue("green", modelChannel(rowWord[row], 1, shade), green);
		checkValue("blue", modelChannel(rowWord[row], 2, shade), blue);
	endtask

	// Blank delays at each pixel strobe, sampled mid-cycle
	always @(negedge CLK_48M) begin
		if (nRESET === 1'b1 && cePixel === 1'b1) begin
			checkValue("vblank", pastBlank(vblankHistory, 1), vblank);
			checkValue("hblank", pastBlank(hblankHistory, 2), hblank);
			vblankHistory = {vblankHistory[2:0], vblankIn};
			hblankHistory = {hblankHistory[2:0], hblankIn};
			blankChecks++;
		end
	end

	//======================================================================
	// Sequence
	//======================================================================

	initial begin
		CLK_48M      = 1'b0;
		nRESET       = 1'b0;
		cpuPalAddr   = '0;
		cpuPalData   = '0;
		cpuPalWrite  = 1'b0;
		latchWrite   = 1'b0;
		latchAddr    = '0;
		pixelPalAddr = '0;
		hblankIn     = 1'b0;
		vblankIn     = 1'b0;
		errorCount   = 0;
		timeoutCount = 0;
		blankChecks  = 0;
		hblankHistory = '0;
		vblankHistory = '0;
		void'($urandom(75489));
		// Rows 4 and 5 share an address across both banks; random rows keep address bit 11 set
		for (int i = 0; i < ROWS; i++) begin
			rowHblank[i] = 1'($urandom);
			rowVblank[i] = 1'($urandom);
			if (i < 6) begin
				rowWord[i]   = CORNER_WORDS[i];
				rowAddr[i]   = (i >= 4) ? 12'h0A5 : 12'(16 + i);
				rowBank[i]   = (i == 5);
				rowShadow[i] = 1'b0;
			end else begin
				rowWord[i]   = 16'($urandom);
				rowAddr[i]   = 12'h800 | 12'($urandom);
				rowBank[i]   = 1'($urandom);
				rowShadow[i] = 1'($urandom);
			end
		end
		for (int i = 0; i < 16; i++) begin
			stepClock();
			checkIdle();
		end
		nRESET = 1'b1;
		checkIdle();
		// First pulse and every later one DIVIDE cycles apart
		for (int p = 0; p < 4; p++) begin
			waitPixel();
			checkValue("cePixel interval", 8'(DIVIDE), 8'(gap));
		end
		for (int i = 0; i < ROWS; i++) begin
			writeLatch(neoVideoPkg::LATCH_PALBANK, rowBank[i]);
			writePalette(i);
			showPixel(i, rowShadow[i]);
		end
		// Each bank under its own flag
		showPixel(4, 1'b0);
		showPixel(5, 1'b0);
		// Shadow on, then off again
		showPixel(1, 1'b1);
		showPixel(1, 1'b0);
		showPixel(ROWS - 1, 1'b1);
		showPixel(ROWS - 1, 1'b0);
		if (blankChecks == 0) begin
			$display("No blank timing checks ran");
			errorCount++;
		end
		$display("Errors: %0d mismatches, %0d timeouts, %0d blank checks", errorCount,
			timeoutCount, blankChecks);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+bench
hdl/neoVideoPkg.sv
hdl/pixelClockGen.sv
hdl/systemLatch.sv
hdl/paletteRam.sv
hdl/videoOutput.sv
hdl/neoVideoTop.sv
bench/tbNeoVideo.sv

// File: Bender.yml
package:
  name: neo_video

sources:
  - files:
      - hdl/neoVideoPkg.sv
      - hdl/pixelClockGen.sv
      - hdl/systemLatch.sv
      - hdl/paletteRam.sv
      - hdl/videoOutput.sv
      - hdl/neoVideoTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tbNeoVideo.sv
